// File: compile.f
logic/cpubus_pkg.sv
logic/bus_frame_seq.sv
logic/bus_serializer.sv
logic/accum_cpu.sv
logic/cpubus_top.sv
verif/cpubus_chk.sv
verif/cpubus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cpubus testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cpubus_tb \
    -Mdir obj_dir -f compile.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/Vcpubus_tb +verilator+error+limit+100); then
  echo "$out"
  echo "Simulation exited with an error status"
  exit 1
fi
echo "$out"

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1

// File: verif/cpubus_tb.sv
// Testbench for cpubus_top: clock, reset, byte-level memory model,
// program image, frame scoreboard and closing report

`timescale 1ns/1ps

module cpubus_tb;
  import cpubus_pkg::*;

  localparam int          sync_timeout    = 20;  // Cycles allowed for one sync
  localparam int          frames_per_pass = 10;
  localparam int          frame_total     = 21;  // Two passes and the fetch after the jump
  localparam logic [23:0] imm_a           = 24'h5a_c3e1;
  localparam logic [31:0] addr_x          = 32'h0000_0040;
  localparam logic [31:0] addr_y          = 32'h0000_0044;
  localparam logic [31:0] addr_z          = 32'h0000_0048;
  localparam logic [31:0] addr_w          = 32'h0000_004c;

  logic        clk;
  logic        reset;
  logic [7:0]  bus_rdata;
  logic [7:0]  bus_addr;
  logic [7:0]  bus_wdata;
  logic [7:0]  bus_oe;
  logic        bus_sync;

  logic [31:0] mem [0:255];   // Word-addressed program and data image
  logic [31:0] write_log [$]; // Write data in bus order
  logic [31:0] exp_store_x;
  logic [31:0] exp_store_w;
  integer      seed;
  int          mismatches;
  int          timeouts;
  int          chk_fails;
  bit          timed_out;

  cpubus_top cpubus_top_inst (
    .clk       (clk),
    .reset     (reset),
    .bus_rdata (bus_rdata),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_oe    (bus_oe),
    .bus_sync  (bus_sync)
  );

  always #20 clk = ~clk;

  function automatic instr_t make_instr(input logic [7:0] opcode, input logic [31:0] arg);
    instr_t ins;
    ins.opcode  = opcode;
    ins.operand = arg[23:0];
    return ins;
  endfunction

  task automatic load_image();
    logic [8:0] i;
    for (i = 9'd0; i < 9'd256; i++) begin
      mem[i[7:0]] = 32'hc0de_0000 | {21'd0, i, 2'b00};  // Fill tied to the address
    end
    mem[0] = make_instr(op_load_imm, {8'h00, imm_a});
    mem[1] = make_instr(op_store, addr_x);
    mem[2] = make_instr(op_load, addr_y);
    mem[3] = make_instr(op_add, addr_z);
    mem[4] = make_instr(op_store, addr_w);
    mem[5] = make_instr(op_jump, reset_vector);
    mem[addr_y[9:2]] = $random(seed);
    mem[addr_z[9:2]] = $random(seed);
    exp_store_x = {8'h00, imm_a};
    exp_store_w = mem[addr_y[9:2]] + mem[addr_z[9:2]];  // Wraps modulo 2^32
  endtask

  // Bus frames of one program pass, fetches at 0, 4 ... 20
  function automatic logic [31:0] expected_addr(input int slot);
    case (slot)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0004;
      2:       return addr_x;
      3:       return 32'h0000_0008;
      4:       return addr_y;
      5:       return 32'h0000_000c;
      6:       return addr_z;
      7:       return 32'h0000_0010;
      8:       return addr_w;
      default: return 32'h0000_0014;  // Jump instruction
    endcase
  endfunction

  function automatic bit expected_write(input int slot);
    return (slot == 2) || (slot == 8);
  endfunction

  function automatic string frame_test_name(input int slot);
    if (slot == 2 || slot == 4 || slot == 6 || slot == 8) begin
      return "data_addr";
    end
    return "fetch_addr";
  endfunction

  task automatic wait_for_sync(output bit found);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!bus_sync && waited < sync_timeout) begin
      @(negedge clk);
      waited++;
    end
    found = bus_sync;
  endtask

  // Collects one frame from the pins, checks it and answers reads
  task automatic serve_frame(input int frame);
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] word;
    logic [31:0] exp_wdata;
    logic [7:0]  oe_all;
    string       wname;
    bit          is_write;
    bit          found;
    int          slot;
    int          k;
    slot = frame % frames_per_pass;
    wait_for_sync(found);
    if (!found) begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout: no bus_sync within %0d cycles for frame %0d", sync_timeout, frame);
      return;
    end
    addr   = {bus_addr, 24'h0};
    wdata  = {bus_wdata, 24'h0};
    oe_all = bus_oe;
    for (k = 1; k < 4; k++) begin
      @(negedge clk);
      addr   = {bus_addr, addr[31:8]};  // Low byte first
      wdata  = {bus_wdata, wdata[31:8]};
      oe_all = oe_all & bus_oe;
    end
    is_write = (oe_all == 8'hff);
    assert (addr == expected_addr(slot)) else begin
      mismatches++;
      $display("MISMATCH %s frame %0d: expected %h, actual %h",
               frame_test_name(slot), frame, expected_addr(slot), addr);
    end
    assert (is_write == expected_write(slot)) else begin
      mismatches++;
      $display("MISMATCH bus_dir frame %0d: expected %0d, actual %0d",
               frame, expected_write(slot), is_write);
    end
    if (is_write) begin
      exp_wdata = (slot == 2) ? exp_store_x : exp_store_w;
      wname     = (slot == 2) ? "store_imm" : "load_add";
      assert (wdata == exp_wdata) else begin
        mismatches++;
        $display("MISMATCH %s frame %0d: expected %h, actual %h", wname, frame, exp_wdata, wdata);
      end
      write_log.push_back(wdata);
      mem[addr[9:2]] = wdata;
      bus_rdata = 8'h00;
    end else begin
      word = mem[addr[9:2]];
      bus_rdata = word[7:0];  // Sampled at the end of phase 5
      for (k = 1; k < 4; k++) begin
        @(negedge clk);
        word = word >> 8;
        bus_rdata = word[7:0];
      end
    end
  endtask

  // Second pass must repeat the writes of the first
  task automatic compare_passes();
    int k;
    assert (write_log.size() == 4) else begin
      mismatches++;
      $display("MISMATCH write_count: expected %0d, actual %0d", 4, write_log.size());
    end
    for (k = 0; k < 2 && k + 2 < write_log.size(); k++) begin
      assert (write_log[k + 2] == write_log[k]) else begin
        mismatches++;
        $display("MISMATCH loop_repeat write %0d: expected %h, actual %h",
                 k, write_log[k], write_log[k + 2]);
      end
    end
  endtask

  initial begin
    int frame;
    seed       = 32'h7dac;
    clk        = 1'b0;
    reset      = 1'b1;
    bus_rdata  = 8'h00;
    mismatches = 0;
    timeouts   = 0;
    timed_out  = 1'b0;
    load_image();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (frame = 0; frame < frame_total; frame++) begin
      serve_frame(frame);
      if (timed_out) break;
    end
    if (!timed_out) compare_passes();
    repeat (10) @(negedge clk);  // Let pending frame assertions complete
    chk_fails = cpubus_top_inst.cpubus_chk_inst.fail_count;
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, chk_fails);
    if (mismatches == 0 && timeouts == 0 && chk_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verif/cpubus_chk.sv
// Concurrent assertions on bus frame timing, pin direction, address and
// write data bytes, attached to cpubus_top by bind

`timescale 1ns/1ps

module cpubus_chk (
  input logic                 clk,
  input logic                 reset,
  input logic                 bus_sync,
  input logic [7:0]           bus_oe,
  input logic [7:0]           bus_addr,
  input logic [7:0]           bus_wdata,
  input cpubus_pkg::bus_req_t req
);

  int fail_count = 0;  // Total of all failed assertions

  first_sync_a: assert property (@(posedge clk)
    $fell(reset) |-> !bus_sync ##1 !bus_sync ##1 bus_sync)  // Third cycle after release
    else begin
      fail_count++;
      $error("first bus_sync not at its fixed cycle");
    end

  sync_period_a: assert property (@(posedge clk) disable iff (reset)
    bus_sync |=> !bus_sync ##1 !bus_sync ##1 !bus_sync ##1 !bus_sync
      ##1 !bus_sync ##1 !bus_sync ##1 !bus_sync ##1 !bus_sync ##1 bus_sync)
    else begin
      fail_count++;
      $error("bus_sync does not recur every 9 cycles");
    end

  // Pins stay released whenever the request is a read
  read_dir_a: assert property (@(posedge clk) disable iff (reset)
    !req.write |-> bus_oe == 8'h00)
    else begin
      fail_count++;
      $error("bus_oe driven during a read frame");
    end

  addr_bytes_a: assert property (@(posedge clk) disable iff (reset)
    bus_sync |-> (bus_addr == req.addr[7:0]) ##1 (bus_addr == req.addr[15:8])
      ##1 (bus_addr == req.addr[23:16]) ##1 (bus_addr == req.addr[31:24]))
    else begin
      fail_count++;
      $error("address bytes out of order on bus_addr");
    end

  write_bytes_a: assert property (@(posedge clk) disable iff (reset)
    bus_sync && req.write |->
      (bus_oe == 8'hff && bus_wdata == req.wdata[7:0])
      ##1 (bus_oe == 8'hff && bus_wdata == req.wdata[15:8])
      ##1 (bus_oe == 8'hff && bus_wdata == req.wdata[23:16])
      ##1 (bus_oe == 8'hff && bus_wdata == req.wdata[31:24])
      ##1 (bus_oe == 8'h00))  // Released for the read phases
    else begin
      fail_count++;
      $error("write frame bytes or bus_oe wrong");
    end

  reset_vals_a: assert property (@(posedge clk)
    reset |=> bus_oe == 8'h00 && !bus_sync)
    else begin
      fail_count++;
      $error("bus_oe or bus_sync not cleared by reset");
    end

endmodule

bind cpubus_top cpubus_chk cpubus_chk_inst (
  .clk       (clk),
  .reset     (reset),
  .bus_sync  (bus_sync),
  .bus_oe    (bus_oe),
  .bus_addr  (bus_addr),
  .bus_wdata (bus_wdata),
  .req       (req)
);

// File: logic/cpubus_top.sv
// Top level of the accumulator processor and its byte-serial bus handler

`timescale 1ns/1ps

module cpubus_top (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] bus_rdata,
  output logic [7:0] bus_addr,
  output logic [7:0] bus_wdata,
  output logic [7:0] bus_oe,
  output logic       bus_sync
);
  import cpubus_pkg::*;

  phase_t      phase;     // Current frame phase
  logic        cpu_step;  // Processor advance strobe, phase 0
  bus_req_t    req;       // Request held for the frame
  logic [31:0] rdata;     // Assembled read word

  bus_frame_seq bus_frame_seq_inst (
    .clk      (clk),
    .reset    (reset),
    .phase    (phase),
    .cpu_step (cpu_step)
  );

  bus_serializer bus_serializer_inst (
    .clk       (clk),
    .reset     (reset),
    .phase     (phase),
    .req       (req),
    .bus_rdata (bus_rdata),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_oe    (bus_oe),
    .bus_sync  (bus_sync),
    .rdata     (rdata)
  );

  accum_cpu accum_cpu_inst (
    .clk      (clk),
    .reset    (reset),
    .cpu_step (cpu_step),
    .rdata    (rdata),
    .req      (req)
  );

endmodule

// File: logic/accum_cpu.sv
// Accumulator processor with fetch and execute frames, program counter
// and accumulator, one step per bus frame

`timescale 1ns/1ps

module accum_cpu (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cpu_step,
  input  logic [31:0]          rdata,
  output cpubus_pkg::bus_req_t req
);
  import cpubus_pkg::*;

  typedef enum logic {
    st_fetch,  // Frame in flight reads an instruction
    st_exec    // Frame in flight reads or writes a data word
  } state_t;

  state_t      state;
  state_t      state_next;
  logic        started;       // Set once the first frame has been issued
  logic [31:0] pc;            // Address of the last fetched instruction
  logic [31:0] pc_next;
  logic [31:0] pc_inc;
  logic [31:0] acc;
  logic [31:0] acc_next;
  logic [7:0]  exec_op;       // Opcode waiting for its data frame
  logic [7:0]  exec_op_next;
  bus_req_t    req_next;
  instr_t      instr;
  logic [31:0] operand;

  assign instr   = rdata;
  assign operand = {8'd0, instr.operand};
  assign pc_inc  = pc + 32'd4;

  always_comb begin
    state_next   = state;
    pc_next      = pc;
    acc_next     = acc;
    exec_op_next = exec_op;
    req_next     = req;

    case (state)
      st_fetch: begin
        // Default is the next sequential fetch
        pc_next        = pc_inc;
        req_next.addr  = pc_inc;
        req_next.wdata = '0;
        req_next.write = 1'b0;
        case (instr.opcode)
          op_load_imm: acc_next = operand;
          op_jump: begin
            pc_next       = operand;
            req_next.addr = operand;
          end
          op_load, op_add, op_store: begin
            req_next.addr  = operand;  // Data frame to the operand address
            req_next.wdata = acc;
            req_next.write = (instr.opcode == op_store);
            exec_op_next   = instr.opcode;
            state_next     = st_exec;
          end
          default: ;  // Unknown opcode, skip to next instruction
        endcase
      end

      st_exec: begin
        case (exec_op)
          op_load: acc_next = rdata;
          op_add:  acc_next = acc + rdata;  // Wraps modulo 2^32
          default: ;  // Store has nothing to take back
        endcase
        req_next.addr  = pc;  // pc already points past the instruction
        req_next.wdata = '0;
        req_next.write = 1'b0;
        state_next     = st_fetch;
      end

      default: state_next = st_fetch;
    endcase
  end

  // The first step after reset only launches the reset fetch, which is
  // already on req, so no read data is consumed then
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_fetch;
      started <= 1'b0;
      pc      <= reset_vector;
      req     <= '{addr: reset_vector, wdata: 32'd0, write: 1'b0};
    end else if (cpu_step) begin
      started <= 1'b1;
      if (started) begin
        state <= state_next;
        pc    <= pc_next;
        req   <= req_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_step && started) begin
      acc     <= acc_next;
      exec_op <= exec_op_next;
    end
  end

endmodule

// File: logic/bus_serializer.sv
// Byte-serial bus handler: address and write data out, read word in,
// data pin direction and sync pulse

`timescale 1ns/1ps

module bus_serializer (
  input  logic                 clk,
  input  logic                 reset,
  input  cpubus_pkg::phase_t   phase,
  input  cpubus_pkg::bus_req_t req,
  input  logic [7:0]           bus_rdata,
  output logic [7:0]           bus_addr,
  output logic [7:0]           bus_wdata,
  output logic [7:0]           bus_oe,
  output logic                 bus_sync,
  output logic [31:0]          rdata
);

  logic       drive_phase;    // Phases 1 to 4 put out one byte each
  logic       capture_phase;  // Phases 5 to 8 take in one byte each
  logic [1:0] byte_sel;       // Byte index for the drive phases
  logic [7:0] addr_byte;
  logic [7:0] wdata_byte;

  assign drive_phase   = (phase >= 4'd1) && (phase <= 4'd4);
  assign capture_phase = (phase >= 4'd5) && (phase <= 4'd8);

  // Phase 1 maps to byte 0 ... phase 4 maps to byte 3
  assign byte_sel = phase[1:0] - 2'd1;

  // Least significant byte first
  assign addr_byte  = req.addr[{byte_sel, 3'b000} +: 8];
  assign wdata_byte = req.wdata[{byte_sel, 3'b000} +: 8];

  // Pin side, one cycle behind the phase that selects the byte
  always_ff @(posedge clk) begin
    if (reset) begin
      bus_addr  <= '0;
      bus_wdata <= '0;
      bus_oe    <= '0;
      bus_sync  <= 1'b0;
    end else begin
      bus_sync <= (phase == 4'd1);  // Marks address byte 0 on the pins
      if (drive_phase) begin
        bus_addr  <= addr_byte;
        bus_wdata <= wdata_byte;
        bus_oe    <= {8{req.write}};  // Drive data pins only for writes
      end else begin
        bus_oe <= '0;  // Release pins for the read bytes
      end
    end
  end

  // Read word assembly
  // Bytes arrive low first and shift down, so byte 0 lands in [7:0]
  // after the fourth capture, ready when phase 0 begins
  always_ff @(posedge clk) begin
    if (reset) begin
      rdata <= '0;
    end else if (capture_phase) begin
      rdata <= {bus_rdata, rdata[31:8]};
    end
  end

endmodule

// File: logic/bus_frame_seq.sv
// Frame phase counter with processor step strobe

`timescale 1ns/1ps

module bus_frame_seq (
  input  logic               clk,
  input  logic               reset,
  output cpubus_pkg::phase_t phase,
  output logic               cpu_step
);
  import cpubus_pkg::*;

  localparam phase_t phase_last = phase_t'(frame_len - 1);

  logic at_last;  // Last cycle of the frame

  assign at_last = (phase == phase_last);

  // Counts 0..8 and wraps, starting at 0 in the first cycle after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else if (at_last) begin
      phase <= '0;
    end else begin
      phase <= phase + phase_t'(1);
    end
  end

  // The processor advances once per frame, in phase 0
  assign cpu_step = (phase == '0);

endmodule

// File: logic/cpubus_pkg.sv
// Shared frame constants, opcode values, bus request and instruction types
// for the byte-serial accumulator processor subsystem

package cpubus_pkg;

  // One bus transaction is a fixed frame of nine clock cycles
  localparam int frame_len = 9;

  typedef logic [3:0] phase_t;  // Position inside the frame, 0 to frame_len-1

  // Instruction opcodes
  localparam logic [7:0] op_load_imm = 8'h01;  // acc = operand
  localparam logic [7:0] op_load     = 8'h02;  // acc = mem[operand]
  localparam logic [7:0] op_add      = 8'h03;  // acc = acc + mem[operand]
  localparam logic [7:0] op_store    = 8'h04;  // mem[operand] = acc
  localparam logic [7:0] op_jump     = 8'h05;  // pc = operand

  // First fetch address after reset
  localparam logic [31:0] reset_vector = 32'h0000_0000;

  // Bus request, held stable by the processor for the whole frame
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        write;
  } bus_req_t;

  // Instruction word, operand is zero-extended to 32 bits on use
  typedef struct packed {
    logic [7:0]  opcode;
    logic [23:0] operand;
  } instr_t;

endpackage
